// File: bench/icache_golden.txt
# columns: vaddr flush_before expect_miss expect_fault expect_data (hex)
# data for vaddr v is (v + 10000000) xor a5a50000, unused on a fault
00000100 0 1 0 b5a50100
00000104 0 0 0 b5a50104
00000108 0 0 0 b5a50108
0000010c 0 0 0 b5a5010c
00000110 0 0 0 b5a50110
00000114 0 0 0 b5a50114
00000118 0 0 0 b5a50118
0000011c 0 0 0 b5a5011c
80000040 0 0 1 00000000
00000060 0 1 0 b5a50060
00000260 0 1 0 b5a50260
00000460 0 1 0 b5a50460
00000660 0 1 0 b5a50660
00000060 0 0 0 b5a50060
00000860 0 1 0 b5a50860
00000460 0 1 0 b5a50460
00000060 0 0 0 b5a50060
00000660 0 0 0 b5a50660
00000260 0 1 0 b5a50260
00000100 1 1 0 b5a50100
00000104 0 0 0 b5a50104

// File: bench/icache_properties.sv
// concurrent checks on the cache controller handshakes, bound into every icache_ctrl instance
`timescale 1ns/1ps
`default_nettype none

module icache_properties (
  input logic clk_i,
  input logic rst_i,
  input logic ar_valid_i,
  input logic ar_ready_i,
  input logic r_ready_i,
  input logic fetch_valid_i,
  input logic flush_i,
  input logic flush_done_i
);

  // read address request stays up until the bus takes it
  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
    (ar_valid_i && !ar_ready_i) |=> ar_valid_i)
    else $error("ar_valid dropped before ar_ready");

  // a refill and a completion never share a cycle
  refill_vs_done: assert property (@(posedge clk_i) disable iff (!rst_i)
    !(r_ready_i && fetch_valid_i))
    else $error("r_ready and fetch_valid high together");

  flush_ack: assert property (@(posedge clk_i) disable iff (!rst_i)
    flush_done_i |-> flush_i)
    else $error("flush_done without flush request");

endmodule

bind icache_ctrl icache_properties u_props (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .ar_valid_i    (ar_valid_o),
  .ar_ready_i    (ar_ready_i),
  .r_ready_i     (r_ready_o),
  .fetch_valid_i (fetch_valid_o),
  .flush_i       (flush_i),
  .flush_done_i  (flush_done_o)
);

`default_nettype wire

// File: bench/tb_icache.sv
// testbench for the instruction cache that replays the golden fetch list against MMU and bus models
`timescale 1ns/1ps
`default_nettype none

module tb_icache
  import icache_pkg::*;
;

  logic  clk_i;
  logic  rst_i;
  logic  fetch_req_i;
  addr_t fetch_vaddr_i;
  logic  fetch_ready_o;
  logic  fetch_valid_o;
  word_t fetch_data_o;
  logic  fetch_fault_o;
  addr_t fetch_vaddr_o;
  logic  mmu_req_o;
  addr_t mmu_vaddr_o;
  logic  mmu_valid_i;
  addr_t mmu_paddr_i;
  logic  mmu_fault_i;
  logic  ar_valid_o;
  addr_t ar_addr_o;
  logic  ar_ready_i;
  logic  r_valid_i;
  beat_t r_data_i;
  logic  r_ready_o;
  logic  flush_i;
  logic  flush_done_o;
  logic  miss_o;

  int seed = 32'h42e1a2d2;
  int errors = 0;
  int checks = 0;
  int n_lines = 0;
  logic loaded = 1'b0;

  // golden entries
  addr_t gold_vaddr [$];
  logic  gold_flush [$];
  logic  gold_miss  [$];
  logic  gold_fault [$];
  word_t gold_data  [$];

  // model state
  int    mmu_wait = 0;
  addr_t rd_base;
  int    beats_left = 0;
  int    beat_idx = 0;

  icache_top uut (.*);

  always #10 clk_i = ~clk_i;

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return r % n;
  endfunction

  // each word reads as its physical address xor a fixed mask
  function automatic beat_t mem_beat(input addr_t a);
    return {(a + 32'd4) ^ 32'hA5A5_0000, a ^ 32'hA5A5_0000};
  endfunction

  // ============================================================
  // translation and refill bus models
  // ============================================================
  always @(posedge clk_i) begin
    if (rst_i) begin
      if (mmu_valid_i) begin
        mmu_valid_i <= 1'b0;
        mmu_wait = rand_below(3);
      end else if (mmu_req_o) begin
        if (mmu_wait == 0) begin
          mmu_valid_i <= 1'b1;
          mmu_paddr_i <= mmu_vaddr_o + 32'h1000_0000;
          mmu_fault_i <= mmu_vaddr_o[31];
        end else begin
          mmu_wait = mmu_wait - 1;
        end
      end
      if (ar_valid_o && ar_ready_i) begin
        rd_base = ar_addr_o;
        beats_left = 4;
        beat_idx = 0;
      end
      ar_ready_i <= (rand_below(3) == 0);
      if (r_valid_i && r_ready_o) begin
        beat_idx = beat_idx + 1;
        beats_left = beats_left - 1;
        r_valid_i <= 1'b0;
      end
      // a beat on offer stays until taken
      if (!(r_valid_i && !r_ready_o) && beats_left > 0 && rand_below(3) != 0) begin
        r_valid_i <= 1'b1;
        r_data_i  <= mem_beat(rd_base + addr_t'(beat_idx * 8));
      end
    end
  end

  // ============================================================
  // golden file load
  // ============================================================
  task automatic load_golden();
    int fd;
    int cnt;
    string line;
    logic [31:0] v;
    logic [31:0] f;
    logic [31:0] m;
    logic [31:0] ft;
    logic [31:0] d;
    fd = $fopen("bench/icache_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file bench/icache_golden.txt");
      errors = errors + 1;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%h %h %h %h %h", v, f, m, ft, d);
          if (cnt == 5) begin
            gold_vaddr.push_back(v);
            gold_flush.push_back(f[0]);
            gold_miss.push_back(m[0]);
            gold_fault.push_back(ft[0]);
            gold_data.push_back(d);
          end
        end
      end
      $fclose(fd);
      n_lines = gold_vaddr.size();
    end
  endtask

  // watchdog sized from the golden list
  initial begin
    wait (loaded);
    repeat (n_lines * 200 + 20) @(posedge clk_i);
    $display("timeout, the fetch sequence did not finish in %0d cycles", n_lines * 200);
    $display("sim failed");
    $finish;
  end

  // ============================================================
  // stimulus and checks once per clock
  // ============================================================
  initial begin
    int   next_idx;
    int   pend;
    int   cur;
    int   miss_cnt;
    logic have_pend;
    logic busy;
    logic flushed;
    logic run;
    word_t rule_data;
    clk_i = 1'b0;
    rst_i = 1'b0;
    fetch_req_i = 1'b0;
    fetch_vaddr_i = '0;
    mmu_valid_i = 1'b0;
    mmu_paddr_i = '0;
    mmu_fault_i = 1'b0;
    ar_ready_i = 1'b0;
    r_valid_i = 1'b0;
    r_data_i = '0;
    flush_i = 1'b0;
    next_idx = 0;
    pend = 0;
    cur = 0;
    miss_cnt = 0;
    have_pend = 1'b0;
    busy = 1'b0;
    flushed = 1'b0;
    run = 1'b1;
    load_golden();
    loaded = 1'b1;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b1;
    while (run) begin
      @(posedge clk_i);
      // monitor the values from the cycle just ended
      if (miss_o) begin
        miss_cnt = miss_cnt + 1;
      end
      if (fetch_valid_o) begin
        checks = checks + 1;
        if (!busy) begin
          $display("completion seen with no fetch outstanding at %0t", $time);
          errors = errors + 1;
        end else begin
          if (fetch_vaddr_o != gold_vaddr[cur]) begin
            $display("FAIL %0t vaddr %h returned %h", $time, gold_vaddr[cur], fetch_vaddr_o);
            errors = errors + 1;
          end
          if (fetch_fault_o != gold_fault[cur]) begin
            $display("FAIL %0t vaddr %h fault %b expected %b", $time, gold_vaddr[cur],
                     fetch_fault_o, gold_fault[cur]);
            errors = errors + 1;
          end
          if (miss_cnt != int'(gold_miss[cur])) begin
            $display("FAIL %0t vaddr %h miss pulses %0d expected %0d", $time,
                     gold_vaddr[cur], miss_cnt, gold_miss[cur]);
            errors = errors + 1;
          end
          if (!gold_fault[cur]) begin
            rule_data = (gold_vaddr[cur] + 32'h1000_0000) ^ 32'hA5A5_0000;
            if (rule_data != gold_data[cur]) begin
              $display("golden entry for vaddr %h disagrees with the memory rule",
                       gold_vaddr[cur]);
              errors = errors + 1;
            end
            if (fetch_data_o != gold_data[cur]) begin
              $display("FAIL %0t vaddr %h data %h expected %h", $time, gold_vaddr[cur],
                       fetch_data_o, gold_data[cur]);
              errors = errors + 1;
            end
          end
        end
        busy = 1'b0;
      end
      if (flush_done_o) begin
        flushed = 1'b1;
      end
      if (fetch_req_i && fetch_ready_o) begin
        cur = pend;
        busy = 1'b1;
        miss_cnt = 0;
        have_pend = 1'b0;
      end
      // drive the next step
      if (!have_pend && next_idx < n_lines) begin
        pend = next_idx;
        next_idx = next_idx + 1;
        have_pend = 1'b1;
        flushed = 1'b0;
      end
      flush_i <= 1'b0;
      if (have_pend && gold_flush[pend] && !flushed) begin
        // flush is only taken once the cache is idle
        fetch_req_i <= 1'b0;
        if (!busy) begin
          flush_i <= 1'b1;
        end
      end else if (have_pend) begin
        fetch_req_i   <= 1'b1;
        fetch_vaddr_i <= gold_vaddr[pend];
      end else begin
        fetch_req_i <= 1'b0;
      end
      if (!have_pend && !busy && next_idx >= n_lines) begin
        run = 1'b0;
      end
    end
    repeat (2) @(posedge clk_i);
    if (n_lines == 0 || checks != n_lines) begin
      $display("expected %0d completions from the golden list, saw %0d", n_lines, checks);
      errors = errors + 1;
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: icache_top.f
+incdir+logic
logic/icache_pkg.sv
logic/icache_ctrl.sv
logic/icache_ways.sv
logic/icache_plru.sv
logic/icache_top.sv
bench/icache_properties.sv
bench/tb_icache.sv

// File: logic/icache_ctrl.sv
// instruction cache controller FSM, sequences lookup, translation wait, refill and flush
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_ctrl
  import icache_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       fetch_req_i,
  input  addr_t                      fetch_vaddr_i,
  input  logic                       mmu_valid_i,
  input  addr_t                      mmu_paddr_i,
  input  logic                       mmu_fault_i,
  input  logic                       ar_ready_i,
  input  logic                       r_valid_i,
  input  logic                       flush_i,
  input  logic                       hit_i,
  output logic                       fetch_ready_o,
  output logic                       fetch_valid_o,
  output logic                       fetch_fault_o,
  output addr_t                      fetch_vaddr_o,
  output logic                       mmu_req_o,
  output addr_t                      mmu_vaddr_o,
  output logic                       ar_valid_o,
  output addr_t                      ar_addr_o,
  output logic                       r_ready_o,
  output logic                       flush_done_o,
  output logic                       miss_o,
  output logic                       rd_en_o,
  output index_t                     rd_index_o,
  output logic [2:0]                 rd_word_sel_o,
  output tag_t                       phy_tag_o,
  output logic                       cmp_en_o,
  output logic                       wr_beat_en_o,
  output logic [`ICACHE_ROW_WTH-1:0] wr_row_o,
  output logic                       tag_wr_en_o,
  output logic                       flush_all_o
);

  ctrl_state_e state_q, state_d;
  addr_t       vaddr_q, vaddr_d;
  addr_t       paddr_q, paddr_d;
  logic        fault_q, fault_d;
  logic        xlate_ok_q;
  logic        xlate_new;
  logic        xlate_now;
  logic        ar_pend_q;
  beat_cnt_t   beat_cnt_q;
  beat_cnt_t   beat_done;
  logic        accept;
  logic        ar_fire;
  logic        r_fire;

  // ============================================================
  // address and translation bookkeeping
  // ============================================================
  assign accept    = fetch_ready_o && fetch_req_i;
  assign vaddr_d   = accept ? fetch_vaddr_i : vaddr_q;
  // translation only counts while it is asked for
  assign xlate_new = mmu_req_o && mmu_valid_i;
  assign xlate_now = xlate_new || xlate_ok_q;
  assign paddr_d   = xlate_new ? mmu_paddr_i : paddr_q;
  assign fault_d   = xlate_new ? mmu_fault_i : fault_q;

  assign fetch_vaddr_o = vaddr_q;
  assign mmu_vaddr_o   = {vaddr_q[`ICACHE_ADDR_WTH-1:2], 2'b00};
  assign mmu_req_o     = (state_q == READ || state_q == XLATE_WAIT) && !xlate_ok_q;
  assign ar_addr_o     = {paddr_q[`ICACHE_ADDR_WTH-1:`ICACHE_OFFSET_WTH],
                          {`ICACHE_OFFSET_WTH{1'b0}}};

  // array read uses the incoming address when a request is taken
  assign rd_index_o    = vaddr_d[`ICACHE_TAG_LSB-1:`ICACHE_OFFSET_WTH];
  assign rd_word_sel_o = vaddr_d[`ICACHE_OFFSET_WTH-1:2];
  assign phy_tag_o     = paddr_d[`ICACHE_ADDR_WTH-1:`ICACHE_TAG_LSB];

  // beats arrive in ascending order from the line base
  assign beat_done = beat_cnt_t'(`ICACHE_BEATS) - beat_cnt_q;
  assign wr_row_o  = {vaddr_q[`ICACHE_TAG_LSB-1:`ICACHE_OFFSET_WTH],
                      beat_done[`ICACHE_BEAT_SEL_WTH-1:0]};

  assign ar_fire = ar_valid_o && ar_ready_i;
  assign r_fire  = r_valid_i && r_ready_o;

  // ============================================================
  // FSM
  // ============================================================
  always_comb begin
    state_d       = state_q;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    fetch_fault_o = 1'b0;
    ar_valid_o    = 1'b0;
    r_ready_o     = 1'b0;
    flush_done_o  = 1'b0;
    flush_all_o   = 1'b0;
    miss_o        = 1'b0;
    rd_en_o       = 1'b0;
    cmp_en_o      = 1'b0;
    wr_beat_en_o  = 1'b0;
    tag_wr_en_o   = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (flush_i) begin
          flush_done_o = 1'b1;
          flush_all_o  = 1'b1;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            rd_en_o = 1'b1;
            state_d = READ;
          end
        end
      end
      READ: begin
        cmp_en_o = xlate_now && !fault_d;
        if (!xlate_now) begin
          state_d = XLATE_WAIT;
        end else if (fault_d || hit_i) begin
          // done, and the next request may start right here
          fetch_valid_o = 1'b1;
          fetch_fault_o = fault_d;
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            rd_en_o = 1'b1;
            state_d = READ;
          end else begin
            state_d = IDLE;
          end
        end else begin
          state_d = REFILL;
        end
      end
      XLATE_WAIT: begin
        if (xlate_new) begin
          if (fault_d) begin
            fetch_valid_o = 1'b1;
            fetch_fault_o = 1'b1;
            state_d       = IDLE;
          end else begin
            rd_en_o = 1'b1;
            state_d = READ;
          end
        end
      end
      REFILL: begin
        ar_valid_o = ar_pend_q;
        r_ready_o  = !ar_pend_q && (beat_cnt_q != '0);
        if (ar_pend_q) begin
          miss_o = ar_ready_i;
        end else if (beat_cnt_q != '0) begin
          wr_beat_en_o = r_fire;
          tag_wr_en_o  = r_fire && (beat_cnt_q == beat_cnt_t'(1));
        end else begin
          // line complete, look it up again
          rd_en_o = 1'b1;
          state_d = READ;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      state_q    <= IDLE;
      xlate_ok_q <= 1'b0;
      fault_q    <= 1'b0;
      ar_pend_q  <= 1'b0;
      beat_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        xlate_ok_q <= 1'b0;
      end else if (xlate_new) begin
        xlate_ok_q <= 1'b1;
        fault_q    <= mmu_fault_i;
      end
      if (state_q == READ && state_d == REFILL) begin
        ar_pend_q <= 1'b1;
      end else if (ar_fire) begin
        ar_pend_q <= 1'b0;
      end
      if (ar_fire) begin
        beat_cnt_q <= beat_cnt_t'(`ICACHE_BEATS);
      end else if (r_fire) begin
        beat_cnt_q <= beat_cnt_q - beat_cnt_t'(1);
      end
    end
  end

  // address payload
  always_ff @(posedge clk_i) begin
    vaddr_q <= vaddr_d;
    paddr_q <= paddr_d;
  end

endmodule

`default_nettype wire

// File: logic/icache_pkg.sv
// shared types for the instruction cache, imported by every RTL module
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

  // address fields
  typedef logic [`ICACHE_ADDR_WTH-1:0] addr_t;
  typedef logic [`ICACHE_ADDR_WTH-`ICACHE_TAG_LSB-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_WTH-1:0] index_t;

  // data paths
  typedef logic [`ICACHE_BEAT_WTH-1:0] beat_t;
  typedef logic [`ICACHE_WORD_WTH-1:0] word_t;

  // way number and refill beats still to come
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;
  typedef logic [$clog2(`ICACHE_BEATS):0] beat_cnt_t;

  // controller FSM
  typedef enum logic [1:0] {
    IDLE,
    READ,
    XLATE_WAIT,
    REFILL
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: logic/icache_plru.sv
// tree pseudo-LRU state per set, picks the way that a refill overwrites
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_plru
  import icache_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    hit_i,
  input  way_t                    hit_way_i,
  input  index_t                  index_i,
  input  logic [`ICACHE_WAYS-1:0] way_valid_mask_i,
  output way_t                    victim_way_o
);

  // root picks a pair, pair bit picks a way inside it
  logic [`ICACHE_SETS-1:0] root_q;
  logic [1:0]              pair_q [`ICACHE_SETS];
  // set of the lookup now being compared
  index_t                  idx_q;
  logic                    tree_pair;
  logic                    tree_way;

  always_ff @(posedge clk_i) begin
    idx_q <= index_i;
  end

  // record the way just used
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      root_q <= '0;
      pair_q <= '{default: '0};
    end else if (hit_i) begin
      root_q[idx_q]               <= hit_way_i[1];
      pair_q[idx_q][hit_way_i[1]] <= hit_way_i[0];
    end
  end

  always_comb begin
    tree_pair    = ~root_q[idx_q];
    tree_way     = ~pair_q[idx_q][tree_pair];
    victim_way_o = {tree_pair, tree_way};
    // an empty way wins, lowest number first
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!way_valid_mask_i[w]) begin
        victim_way_o = way_t'(w);
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/icache_settings.svh
// instruction cache geometry and address fields, included by the package and every RTL module
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// address and data widths
`define ICACHE_ADDR_WTH 32
`define ICACHE_WORD_WTH 32
`define ICACHE_BEAT_WTH 64

// cache shape, the replacement tree is built for exactly four ways
`define ICACHE_WAYS 4
`define ICACHE_SETS 16
`define ICACHE_BEATS 4

// address fields, 32-byte lines
`define ICACHE_OFFSET_WTH 5
`define ICACHE_INDEX_WTH 4
`define ICACHE_TAG_LSB 9

// beat select inside a line, and data array row
`define ICACHE_BEAT_SEL_WTH 2
`define ICACHE_ROW_WTH (`ICACHE_INDEX_WTH + `ICACHE_BEAT_SEL_WTH)

`endif

// File: logic/icache_top.sv
// instruction cache top level, joins the controller, the way storage and the replacement logic
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  // fetch side
  input  logic  fetch_req_i,
  input  addr_t fetch_vaddr_i,
  output logic  fetch_ready_o,
  output logic  fetch_valid_o,
  output word_t fetch_data_o,
  output logic  fetch_fault_o,
  output addr_t fetch_vaddr_o,
  // address translation
  output logic  mmu_req_o,
  output addr_t mmu_vaddr_o,
  input  logic  mmu_valid_i,
  input  addr_t mmu_paddr_i,
  input  logic  mmu_fault_i,
  // refill read address
  output logic  ar_valid_o,
  output addr_t ar_addr_o,
  input  logic  ar_ready_i,
  // refill read data
  input  logic  r_valid_i,
  input  beat_t r_data_i,
  output logic  r_ready_o,
  // maintenance and status
  input  logic  flush_i,
  output logic  flush_done_o,
  output logic  miss_o
);

  logic                       rd_en;
  index_t                     rd_index;
  logic [2:0]                 rd_word_sel;
  tag_t                       phy_tag;
  logic                       cmp_en;
  logic                       wr_beat_en;
  logic [`ICACHE_ROW_WTH-1:0] wr_row;
  logic                       tag_wr_en;
  logic                       flush_all;
  logic                       hit;
  way_t                       hit_way;
  logic [`ICACHE_WAYS-1:0]    way_valid_mask;
  way_t                       victim_way;

  icache_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_vaddr_i (fetch_vaddr_i),
    .mmu_valid_i   (mmu_valid_i),
    .mmu_paddr_i   (mmu_paddr_i),
    .mmu_fault_i   (mmu_fault_i),
    .ar_ready_i    (ar_ready_i),
    .r_valid_i     (r_valid_i),
    .flush_i       (flush_i),
    .hit_i         (hit),
    .fetch_ready_o (fetch_ready_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_fault_o (fetch_fault_o),
    .fetch_vaddr_o (fetch_vaddr_o),
    .mmu_req_o     (mmu_req_o),
    .mmu_vaddr_o   (mmu_vaddr_o),
    .ar_valid_o    (ar_valid_o),
    .ar_addr_o     (ar_addr_o),
    .r_ready_o     (r_ready_o),
    .flush_done_o  (flush_done_o),
    .miss_o        (miss_o),
    .rd_en_o       (rd_en),
    .rd_index_o    (rd_index),
    .rd_word_sel_o (rd_word_sel),
    .phy_tag_o     (phy_tag),
    .cmp_en_o      (cmp_en),
    .wr_beat_en_o  (wr_beat_en),
    .wr_row_o      (wr_row),
    .tag_wr_en_o   (tag_wr_en),
    .flush_all_o   (flush_all)
  );

  icache_ways u_ways (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .rd_en_i          (rd_en),
    .rd_index_i       (rd_index),
    .rd_word_sel_i    (rd_word_sel),
    .phy_tag_i        (phy_tag),
    .cmp_en_i         (cmp_en),
    .wr_beat_en_i     (wr_beat_en),
    .wr_row_i         (wr_row),
    .tag_wr_en_i      (tag_wr_en),
    .flush_all_i      (flush_all),
    .victim_way_i     (victim_way),
    .r_data_i         (r_data_i),
    .hit_o            (hit),
    .hit_way_o        (hit_way),
    .hit_word_o       (fetch_data_o),
    .way_valid_mask_o (way_valid_mask)
  );

  icache_plru u_plru (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .hit_i            (hit),
    .hit_way_i        (hit_way),
    .index_i          (rd_index),
    .way_valid_mask_i (way_valid_mask),
    .victim_way_o     (victim_way)
  );

endmodule

`default_nettype wire

// File: logic/icache_ways.sv
// tag, valid and data storage for the four cache ways, with registered read and tag compare
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_ways
  import icache_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  // lookup
  input  logic                       rd_en_i,
  input  index_t                     rd_index_i,
  input  logic [2:0]                 rd_word_sel_i,
  input  tag_t                       phy_tag_i,
  input  logic                       cmp_en_i,
  // refill and maintenance
  input  logic                       wr_beat_en_i,
  input  logic [`ICACHE_ROW_WTH-1:0] wr_row_i,
  input  logic                       tag_wr_en_i,
  input  logic                       flush_all_i,
  input  way_t                       victim_way_i,
  input  beat_t                      r_data_i,
  // lookup result
  output logic                       hit_o,
  output way_t                       hit_way_o,
  output word_t                      hit_word_o,
  output logic [`ICACHE_WAYS-1:0]    way_valid_mask_o
);

  localparam int ROWS = `ICACHE_SETS * `ICACHE_BEATS;

  // ============================================================
  // storage
  // ============================================================
  tag_t                    tag_arr  [`ICACHE_SETS][`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0] vld_arr  [`ICACHE_SETS];
  beat_t                   data_arr [ROWS][`ICACHE_WAYS];

  // read capture, one entry per way
  tag_t                    tag_q    [`ICACHE_WAYS];
  beat_t                   beat_q   [`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0] vld_q;
  logic                    half_q;

  logic [`ICACHE_WAYS-1:0] way_hit;
  index_t                  wr_index;

  // the tag goes in with the last beat, same set as the data rows
  assign wr_index = wr_row_i[`ICACHE_ROW_WTH-1:`ICACHE_BEAT_SEL_WTH];

  always_ff @(posedge clk_i) begin
    if (wr_beat_en_i) begin
      data_arr[wr_row_i][victim_way_i] <= r_data_i;
    end
    if (tag_wr_en_i) begin
      tag_arr[wr_index][victim_way_i] <= phy_tag_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      vld_arr <= '{default: '0};
    end else if (flush_all_i) begin
      vld_arr <= '{default: '0};
    end else if (tag_wr_en_i) begin
      vld_arr[wr_index][victim_way_i] <= 1'b1;
    end
  end

  // ============================================================
  // registered read
  // ============================================================
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      vld_q <= '0;
    end else if (rd_en_i) begin
      vld_q <= vld_arr[rd_index_i];
    end
  end

  // 64-bit beat holding the word, plus which half of it
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      tag_q  <= tag_arr[rd_index_i];
      beat_q <= data_arr[{rd_index_i, rd_word_sel_i[2:1]}];
      half_q <= rd_word_sel_i[0];
    end
  end

  // ============================================================
  // compare and word select
  // ============================================================
  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      way_hit[w] = cmp_en_i && vld_q[w] && (tag_q[w] == phy_tag_i);
      if (way_hit[w]) begin
        hit_way_o = way_t'(w);
      end
    end
  end

  assign hit_o            = |way_hit;
  assign way_valid_mask_o = vld_q;

  // upper half of the beat is the higher address
  assign hit_word_o = half_q ? beat_q[hit_way_o][`ICACHE_BEAT_WTH-1:`ICACHE_WORD_WTH]
                             : beat_q[hit_way_o][`ICACHE_WORD_WTH-1:0];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the instruction cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f icache_top.f \
  --top-module tb_icache \
  -o tb_icache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_icache_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
